// ==== common/csr_pkg.sv ====
package csr_pkg;

    localparam int xlen      = 32;
    localparam int csr_num_w = 14;
    localparam int int_w     = 13;
    localparam int hw_int_w  = 8;

    // LIE bit 10 has no interrupt line behind it
    localparam logic [int_w-1:0] ecfg_lie_mask = 13'h1bff;
    localparam logic [xlen-1:0]  timer_idle    = '1;  // Counter parked, timer stopped

    localparam int ecode_w    = 6;
    localparam int esubcode_w = 9;
    localparam int plv_w      = 2;

    typedef enum logic [csr_num_w-1:0] {
        csr_crmd   = 14'h000,
        csr_prmd   = 14'h001,
        csr_ecfg   = 14'h004,
        csr_estat  = 14'h005,
        csr_era    = 14'h006,
        csr_badv   = 14'h007,
        csr_eentry = 14'h00c,
        csr_tcfg   = 14'h041,
        csr_tval   = 14'h042,
        csr_ticlr  = 14'h044
    } csr_addr_e;

    typedef enum logic [ecode_w-1:0] {
        ecode_int = 6'h00,
        ecode_ade = 6'h08,
        ecode_ale = 6'h09,
        ecode_sys = 6'h0b
    } ecode_e;

    localparam logic [esubcode_w-1:0] esubcode_adef = 9'h000;

    // CRMD and PRMD share the same low layout
    localparam int plv_lsb     = 0;
    localparam int ie_bit      = 2;
    localparam int crmd_da_bit = 3;

    localparam int is_sw_lsb    = 0;
    localparam int is_sw_w      = 2;
    localparam int is_hw_lsb    = 2;
    localparam int is_rsvd_bit  = 10;
    localparam int is_timer_bit = 11;
    localparam int is_ipi_bit   = 12;

    localparam int estat_ecode_lsb    = 16;
    localparam int estat_esubcode_lsb = 22;
    localparam int eentry_va_lsb      = 6;

    localparam int tcfg_en_bit       = 0;
    localparam int tcfg_periodic_bit = 1;
    localparam int tcfg_initval_lsb  = 2;
    localparam int ticlr_clr_bit     = 0;

    typedef struct packed {
        logic            we;
        csr_addr_e       num;
        logic [xlen-1:0] wmask;
        logic [xlen-1:0] wvalue;
    } csr_wr_t;

    typedef struct packed {
        logic                  ex;
        logic                  ertn;
        logic [xlen-1:0]       pc;
        ecode_e                ecode;
        logic [esubcode_w-1:0] esubcode;
        logic [xlen-1:0]       vaddr;
    } exc_evt_t;

    typedef struct packed {
        logic [plv_w-1:0]              plv;
        logic                          ie;
        logic [plv_w-1:0]              pplv;
        logic                          pie;
        ecode_e                        ecode;
        logic [esubcode_w-1:0]         esubcode;
        logic [xlen-1:0]               era;
        logic [xlen-1:0]               badv;
        logic [xlen-eentry_va_lsb-1:0] eentry_va;
    } exc_view_t;

    typedef struct packed {
        logic [int_w-1:0]                 lie;
        logic [int_w-1:0]                 is;
        logic                             tcfg_en;
        logic                             tcfg_periodic;
        logic [xlen-tcfg_initval_lsb-1:0] tcfg_initval;
        logic [xlen-1:0]                  tval;
    } int_view_t;

    // New bits where the mask is set, old bits elsewhere
    function automatic logic [xlen-1:0] merge_wr(input logic [xlen-1:0] old_val,
                                                 input logic [xlen-1:0] wmask,
                                                 input logic [xlen-1:0] wvalue);
        return (wmask & wvalue) | (~wmask & old_val);
    endfunction

endpackage

// ==== logic/exc_state_regs.sv ====
`timescale 1ns/10ps
module exc_state_regs (
    input  logic                clk,
    input  logic                reset,
    input  csr_pkg::csr_wr_t    csr_wr,
    input  csr_pkg::exc_evt_t   exc_evt,
    output csr_pkg::exc_view_t  exc_view,
    output logic [31:0]         ex_entry,
    output logic [31:0]         ertn_entry
);
    import csr_pkg::*;

    logic [plv_w-1:0]              crmd_plv;
    logic                          crmd_ie;
    logic [plv_w-1:0]              prmd_pplv;
    logic                          prmd_pie;
    ecode_e                        estat_ecode;
    logic [esubcode_w-1:0]         estat_esubcode;
    logic [xlen-1:0]               era;
    logic [xlen-1:0]               badv;
    logic [xlen-eentry_va_lsb-1:0] eentry_va;

    logic            wr_crmd;
    logic            wr_prmd;
    logic            wr_era;
    logic            wr_eentry;
    logic [xlen-1:0] crmd_next;
    logic [xlen-1:0] prmd_next;
    logic [xlen-1:0] era_next;
    logic [xlen-1:0] eentry_next;
    logic            addr_err;
    logic            fetch_err;

    assign wr_crmd   = csr_wr.we && (csr_wr.num == csr_crmd);
    assign wr_prmd   = csr_wr.we && (csr_wr.num == csr_prmd);
    assign wr_era    = csr_wr.we && (csr_wr.num == csr_era);
    assign wr_eentry = csr_wr.we && (csr_wr.num == csr_eentry);

    assign crmd_next = merge_wr({{(xlen-plv_w-1){1'b0}}, crmd_ie, crmd_plv},
                                csr_wr.wmask, csr_wr.wvalue);
    assign prmd_next = merge_wr({{(xlen-plv_w-1){1'b0}}, prmd_pie, prmd_pplv},
                                csr_wr.wmask, csr_wr.wvalue);
    assign era_next  = merge_wr(era, csr_wr.wmask, csr_wr.wvalue);
    assign eentry_next = merge_wr({eentry_va, {eentry_va_lsb{1'b0}}},
                                  csr_wr.wmask, csr_wr.wvalue);

    assign addr_err  = (exc_evt.ecode == ecode_ade) || (exc_evt.ecode == ecode_ale);
    // An instruction fetch fault reports the PC itself as the bad address
    assign fetch_err = (exc_evt.ecode == ecode_ade) && (exc_evt.esubcode == esubcode_adef);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (exc_evt.ex) begin
            crmd_plv <= '0;  // Handlers run at PLV0 with interrupts masked
            crmd_ie  <= 1'b0;
        end else if (exc_evt.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_crmd) begin
            crmd_plv <= crmd_next[plv_lsb +: plv_w];
            crmd_ie  <= crmd_next[ie_bit];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv      <= '0;
            prmd_pie       <= 1'b0;
            era            <= '0;
            estat_ecode    <= ecode_int;
            estat_esubcode <= '0;
            badv           <= '0;
        end else if (exc_evt.ex) begin
            prmd_pplv      <= crmd_plv;
            prmd_pie       <= crmd_ie;
            era            <= exc_evt.pc;
            estat_ecode    <= exc_evt.ecode;
            estat_esubcode <= exc_evt.esubcode;
            if (addr_err)
                badv <= fetch_err ? exc_evt.pc : exc_evt.vaddr;
        end else begin
            if (wr_prmd) begin
                prmd_pplv <= prmd_next[plv_lsb +: plv_w];
                prmd_pie  <= prmd_next[ie_bit];
            end
            if (wr_era)
                era <= era_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            eentry_va <= '0;
        else if (wr_eentry)
            eentry_va <= eentry_next[xlen-1:eentry_va_lsb];
    end

    assign exc_view.plv       = crmd_plv;
    assign exc_view.ie        = crmd_ie;
    assign exc_view.pplv      = prmd_pplv;
    assign exc_view.pie       = prmd_pie;
    assign exc_view.ecode     = estat_ecode;
    assign exc_view.esubcode  = estat_esubcode;
    assign exc_view.era       = era;
    assign exc_view.badv      = badv;
    assign exc_view.eentry_va = eentry_va;

    assign ex_entry   = {eentry_va, {eentry_va_lsb{1'b0}}};
    assign ertn_entry = era;

    // The writeback stage retires at most one of these per cycle
    a_ex_ertn_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(exc_evt.ex && exc_evt.ertn));

endmodule

// ==== logic/timer_int_regs.sv ====
`timescale 1ns/10ps
module timer_int_regs (
    input  logic               clk,
    input  logic               reset,
    input  csr_pkg::csr_wr_t   csr_wr,
    input  logic [7:0]         hw_int_in,
    input  logic               ipi_int_in,
    output csr_pkg::int_view_t int_view
);
    import csr_pkg::*;

    logic [int_w-1:0]                 ecfg_lie;
    logic [is_sw_w-1:0]               is_sw;
    logic [hw_int_w-1:0]              is_hw;
    logic                             is_timer;
    logic                             is_ipi;
    logic [int_w-1:0]                 is_all;
    logic                             tcfg_en;
    logic                             tcfg_periodic;
    logic [xlen-tcfg_initval_lsb-1:0] tcfg_initval;
    logic [xlen-1:0]                  timer_cnt;

    logic            wr_ecfg;
    logic            wr_estat;
    logic            wr_tcfg;
    logic            ticlr_clr;
    logic [xlen-1:0] ecfg_next;
    logic [xlen-1:0] estat_next;
    logic [xlen-1:0] tcfg_next;

    assign wr_ecfg   = csr_wr.we && (csr_wr.num == csr_ecfg);
    assign wr_estat  = csr_wr.we && (csr_wr.num == csr_estat);
    assign wr_tcfg   = csr_wr.we && (csr_wr.num == csr_tcfg);
    assign ticlr_clr = csr_wr.we && (csr_wr.num == csr_ticlr)
                    && csr_wr.wmask[ticlr_clr_bit] && csr_wr.wvalue[ticlr_clr_bit];

    assign ecfg_next  = merge_wr({{(xlen-int_w){1'b0}}, ecfg_lie},
                                 csr_wr.wmask, csr_wr.wvalue);
    assign estat_next = merge_wr({{(xlen-is_sw_w){1'b0}}, is_sw},
                                 csr_wr.wmask, csr_wr.wvalue);
    assign tcfg_next  = merge_wr({tcfg_initval, tcfg_periodic, tcfg_en},
                                 csr_wr.wmask, csr_wr.wvalue);

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
            is_sw    <= '0;
            is_hw    <= '0;
            is_ipi   <= 1'b0;
        end else begin
            if (wr_ecfg)
                ecfg_lie <= ecfg_next[int_w-1:0] & ecfg_lie_mask;
            if (wr_estat)
                is_sw <= estat_next[is_sw_lsb +: is_sw_w];
            is_hw  <= hw_int_in;  // Sampled every cycle, no latching
            is_ipi <= ipi_int_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (wr_tcfg) begin
            tcfg_en       <= tcfg_next[tcfg_en_bit];
            tcfg_periodic <= tcfg_next[tcfg_periodic_bit];
            tcfg_initval  <= tcfg_next[xlen-1:tcfg_initval_lsb];
        end
    end

    // Enabling through TCFG restarts the count from the freshly written value
    always_ff @(posedge clk) begin
        if (reset)
            timer_cnt <= timer_idle;
        else if (wr_tcfg && tcfg_next[tcfg_en_bit])
            timer_cnt <= {tcfg_next[xlen-1:tcfg_initval_lsb], {tcfg_initval_lsb{1'b0}}};
        else if (tcfg_en && (timer_cnt != timer_idle)) begin
            if ((timer_cnt == '0) && tcfg_periodic)
                timer_cnt <= {tcfg_initval, {tcfg_initval_lsb{1'b0}}};
            else
                timer_cnt <= timer_cnt - xlen'(1);  // One-shot wraps to idle
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            is_timer <= 1'b0;
        else if (timer_cnt == '0)
            is_timer <= 1'b1;
        else if (ticlr_clr)
            is_timer <= 1'b0;
    end

    always_comb begin
        is_all = '0;
        is_all[is_sw_lsb +: is_sw_w]  = is_sw;
        is_all[is_hw_lsb +: hw_int_w] = is_hw;
        is_all[is_timer_bit]          = is_timer;
        is_all[is_ipi_bit]            = is_ipi;
    end

    assign int_view.lie           = ecfg_lie;
    assign int_view.is            = is_all;
    assign int_view.tcfg_en       = tcfg_en;
    assign int_view.tcfg_periodic = tcfg_periodic;
    assign int_view.tcfg_initval  = tcfg_initval;
    assign int_view.tval          = timer_cnt;

    a_is_rsvd_zero: assert property (@(posedge clk) disable iff (reset)
        !int_view.is[is_rsvd_bit] && !int_view.lie[is_rsvd_bit]);

endmodule

// ==== logic/csr_read_combine.sv ====
`timescale 1ns/10ps
module csr_read_combine (
    input  csr_pkg::csr_addr_e csr_num,
    input  csr_pkg::exc_view_t exc_view,
    input  csr_pkg::int_view_t int_view,
    output logic [31:0]        csr_rvalue,
    output logic               has_int
);
    import csr_pkg::*;

    always_comb begin
        csr_rvalue = '0;
        case (csr_num)
            csr_crmd: begin
                csr_rvalue[plv_lsb +: plv_w] = exc_view.plv;
                csr_rvalue[ie_bit]           = exc_view.ie;
                csr_rvalue[crmd_da_bit]      = 1'b1;  // Direct address mode only
            end
            csr_prmd: begin
                csr_rvalue[plv_lsb +: plv_w] = exc_view.pplv;
                csr_rvalue[ie_bit]           = exc_view.pie;
            end
            csr_ecfg:   csr_rvalue[int_w-1:0] = int_view.lie;
            csr_estat: begin
                csr_rvalue[int_w-1:0]                         = int_view.is;
                csr_rvalue[estat_ecode_lsb +: ecode_w]        = exc_view.ecode;
                csr_rvalue[estat_esubcode_lsb +: esubcode_w]  = exc_view.esubcode;
            end
            csr_era:    csr_rvalue = exc_view.era;
            csr_badv:   csr_rvalue = exc_view.badv;
            csr_eentry: csr_rvalue[xlen-1:eentry_va_lsb] = exc_view.eentry_va;
            csr_tcfg: begin
                csr_rvalue[tcfg_en_bit]                = int_view.tcfg_en;
                csr_rvalue[tcfg_periodic_bit]          = int_view.tcfg_periodic;
                csr_rvalue[xlen-1:tcfg_initval_lsb]    = int_view.tcfg_initval;
            end
            csr_tval:   csr_rvalue = int_view.tval;
            // TICLR is write-only and reads back as zero like unlisted numbers
            default:    csr_rvalue = '0;
        endcase
    end

    always_comb begin
        has_int = (|(int_view.is & int_view.lie)) && exc_view.ie;
    end

endmodule

// ==== logic/csr_top.sv ====
`timescale 1ns/10ps
module csr_top (
    input  logic               clk,
    input  logic               reset,
    input  csr_pkg::csr_addr_e csr_num,
    input  csr_pkg::csr_wr_t   csr_wr,
    input  csr_pkg::exc_evt_t  exc_evt,
    input  logic [7:0]         hw_int_in,
    input  logic               ipi_int_in,
    output logic [31:0]        csr_rvalue,
    output logic               has_int,
    output logic [31:0]        ex_entry,
    output logic [31:0]        ertn_entry
);
    import csr_pkg::*;

    exc_view_t exc_view;
    int_view_t int_view;

    // Both register blocks see every write and decode their own numbers
    exc_state_regs i_exc_state_regs (
        .clk        (clk),
        .reset      (reset),
        .csr_wr     (csr_wr),
        .exc_evt    (exc_evt),
        .exc_view   (exc_view),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry)
    );

    timer_int_regs i_timer_int_regs (
        .clk        (clk),
        .reset      (reset),
        .csr_wr     (csr_wr),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .int_view   (int_view)
    );

    csr_read_combine i_csr_read_combine (
        .csr_num    (csr_num),
        .exc_view   (exc_view),
        .int_view   (int_view),
        .csr_rvalue (csr_rvalue),
        .has_int    (has_int)
    );

endmodule

// ==== verif/csr_checker.sv ====
`timescale 1ns/10ps
module csr_checker (
    input  logic              clk,
    input  logic              reset,
    input  logic [13:0]       csr_num,
    input  csr_pkg::csr_wr_t  csr_wr,
    input  csr_pkg::exc_evt_t exc_evt,
    input  logic [7:0]        hw_int_in,
    input  logic              ipi_int_in,
    input  logic [31:0]       csr_rvalue,
    input  logic              has_int,
    input  logic [31:0]       ex_entry,
    input  logic [31:0]       ertn_entry,
    output int                error_count,
    output int                check_count
);
    int errors = 0;
    int checks = 0;

    // Reference copy of every kept register field
    logic [1:0]  plv;
    logic        ie;
    logic [1:0]  pplv;
    logic        pie;
    logic [5:0]  ecode;
    logic [8:0]  esubcode;
    logic [31:0] era;
    logic [31:0] badv;
    logic [31:0] eentry;
    logic [12:0] lie;
    logic [1:0]  is_sw;
    logic [7:0]  is_hw;
    logic        is_timer;
    logic        is_ipi;
    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    logic [31:0] tval;

    assign error_count = errors;
    assign check_count = checks;

    function automatic logic wr_to(input logic [13:0] num);
        return csr_wr.we && (csr_wr.num == num);
    endfunction

    // Flip exactly the old bits that the mask lets the written value change
    function automatic logic [31:0] masked_write(input logic [31:0] old_val);
        return old_val ^ ((old_val ^ csr_wr.wvalue) & csr_wr.wmask);
    endfunction

    function automatic logic [12:0] is_value();
        return {is_ipi, is_timer, 1'b0, is_hw, is_sw};
    endfunction

    function automatic logic [31:0] expected_read(input logic [13:0] num);
        case (num)
            14'h000: return {28'd0, 1'b1, ie, plv};
            14'h001: return {29'd0, pie, pplv};
            14'h004: return {19'd0, lie};
            14'h005: return {1'b0, esubcode, ecode, 3'd0, is_value()};
            14'h006: return era;
            14'h007: return badv;
            14'h00c: return eentry;
            14'h041: return {tcfg_initval, tcfg_periodic, tcfg_en};
            14'h042: return tval;
            default: return 32'd0;
        endcase
    endfunction

    function automatic string read_name(input logic [13:0] num);
        case (num)
            14'h000: return "read CRMD";
            14'h001: return "read PRMD";
            14'h004: return "read ECFG";
            14'h005: return "read ESTAT";
            14'h006: return "read ERA";
            14'h007: return "read BADV";
            14'h00c: return "read EENTRY";
            14'h041: return "read TCFG";
            14'h042: return "read TVAL";
            14'h044: return "read TICLR";
            default: return "read unlisted CSR";
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
        checks++;
        if (exp_val !== act_val) begin
            errors++;
            $display("CHECK FAILED %s: expected %08h, actual %08h at %0t",
                     name, exp_val, act_val, $time);
        end
    endtask

    always @(posedge clk) begin : model_step
        logic [1:0]  old_plv;
        logic        old_ie;
        logic [1:0]  old_pplv;
        logic        old_pie;
        logic [31:0] old_tval;
        logic [31:0] wr_new;
        logic [31:0] tcfg_new;
        if (reset) begin
            {plv, ie, pplv, pie} = '0;
            {ecode, esubcode, era, badv, eentry} = '0;
            {lie, is_sw, is_hw, is_timer, is_ipi} = '0;
            {tcfg_en, tcfg_periodic, tcfg_initval} = '0;
            tval = 32'hffff_ffff;  // Timer parked
        end else begin
            old_plv  = plv;
            old_ie   = ie;
            old_pplv = pplv;
            old_pie  = pie;
            old_tval = tval;
            if (exc_evt.ex) begin
                plv = 2'd0;
                ie  = 1'b0;
            end else if (exc_evt.ertn) begin
                plv = old_pplv;
                ie  = old_pie;
            end else if (wr_to(14'h000)) begin
                wr_new = masked_write({29'd0, old_ie, old_plv});
                plv    = wr_new[1:0];
                ie     = wr_new[2];
            end
            if (exc_evt.ex) begin
                pplv     = old_plv;
                pie      = old_ie;
                era      = exc_evt.pc;
                ecode    = exc_evt.ecode;
                esubcode = exc_evt.esubcode;
                if ((exc_evt.ecode == 6'h08) && (exc_evt.esubcode == 9'd0))
                    badv = exc_evt.pc;  // Fetch fault
                else if ((exc_evt.ecode == 6'h08) || (exc_evt.ecode == 6'h09))
                    badv = exc_evt.vaddr;
            end else begin
                if (wr_to(14'h001)) begin
                    wr_new = masked_write({29'd0, old_pie, old_pplv});
                    pplv   = wr_new[1:0];
                    pie    = wr_new[2];
                end
                if (wr_to(14'h006))
                    era = masked_write(era);
            end
            if (wr_to(14'h00c)) begin
                wr_new = masked_write(eentry);
                eentry = {wr_new[31:6], 6'd0};
            end
            if (wr_to(14'h004)) begin
                wr_new = masked_write({19'd0, lie});
                lie    = wr_new[12:0] & 13'h1bff;
            end
            if (wr_to(14'h005)) begin
                wr_new = masked_write({30'd0, is_sw});
                is_sw  = wr_new[1:0];
            end
            is_hw    = hw_int_in;
            is_ipi   = ipi_int_in;
            tcfg_new = masked_write({tcfg_initval, tcfg_periodic, tcfg_en});
            if (wr_to(14'h041) && tcfg_new[0])
                tval = {tcfg_new[31:2], 2'b00};
            else if (tcfg_en && (tval != 32'hffff_ffff)) begin
                if ((tval == 32'd0) && tcfg_periodic)
                    tval = {tcfg_initval, 2'b00};
                else
                    tval = tval - 32'd1;
            end
            if (wr_to(14'h041)) begin
                tcfg_en       = tcfg_new[0];
                tcfg_periodic = tcfg_new[1];
                tcfg_initval  = tcfg_new[31:2];
            end
            if (old_tval == 32'd0)
                is_timer = 1'b1;
            else if (wr_to(14'h044) && csr_wr.wmask[0] && csr_wr.wvalue[0])
                is_timer = 1'b0;
        end
    end

    // Outputs are settled half a cycle after the inputs move
    always @(negedge clk) begin
        if (!reset) begin
            compare(read_name(csr_num), expected_read(csr_num), csr_rvalue);
            compare("has_int", {31'd0, (|(is_value() & lie)) && ie}, {31'd0, has_int});
            compare("ex_entry", eentry, ex_entry);
            compare("ertn_entry", era, ertn_entry);
        end
    end

endmodule

// ==== verif/csr_tb.sv ====
`timescale 1ns/10ps
module csr_tb;
    import csr_pkg::*;

    localparam int reset_cycles   = 10;
    localparam int run_cycles     = 4000;
    localparam int timeout_cycles = run_cycles + run_cycles / 4;  // A quarter of margin

    logic        clk = 1'b0;
    logic        reset;
    csr_addr_e   csr_num;
    csr_wr_t     csr_wr;
    exc_evt_t    exc_evt;
    logic [7:0]  hw_int_in;
    logic        ipi_int_in;
    logic [31:0] csr_rvalue;
    logic        has_int;
    logic [31:0] ex_entry;
    logic [31:0] ertn_entry;
    int          error_count;
    int          check_count;

    always #5 clk = ~clk;

    csr_top i_csr_top (
        .clk        (clk),
        .reset      (reset),
        .csr_num    (csr_num),
        .csr_wr     (csr_wr),
        .exc_evt    (exc_evt),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .csr_rvalue (csr_rvalue),
        .has_int    (has_int),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry)
    );

    csr_checker i_csr_checker (
        .clk         (clk),
        .reset       (reset),
        .csr_num     (csr_num),
        .csr_wr      (csr_wr),
        .exc_evt     (exc_evt),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .csr_rvalue  (csr_rvalue),
        .has_int     (has_int),
        .ex_entry    (ex_entry),
        .ertn_entry  (ertn_entry),
        .error_count (error_count),
        .check_count (check_count)
    );

    // Index 10 gives a CSR number that the design does not implement
    function automatic csr_addr_e pick_csr_num(input int unsigned sel);
        case (sel)
            0:       return csr_crmd;
            1:       return csr_prmd;
            2:       return csr_ecfg;
            3:       return csr_estat;
            4:       return csr_era;
            5:       return csr_badv;
            6:       return csr_eentry;
            7:       return csr_tcfg;
            8:       return csr_tval;
            9:       return csr_ticlr;
            default: return csr_addr_e'(14'h030);
        endcase
    endfunction

    function automatic ecode_e pick_ecode(input int unsigned sel);
        case (sel)
            0:       return ecode_int;
            1:       return ecode_ade;
            2:       return ecode_ale;
            default: return ecode_sys;
        endcase
    endfunction

    task automatic drive_cycle();
        int unsigned roll;
        csr_num       = pick_csr_num($urandom_range(0, 10));
        csr_wr.we     = ($urandom_range(0, 99) < 40);
        csr_wr.num    = pick_csr_num($urandom_range(0, 10));
        csr_wr.wmask  = $urandom();
        csr_wr.wvalue = $urandom();
        // Short initial values so the timer runs out often
        if (csr_wr.num == csr_tcfg)
            csr_wr.wvalue[31:2] = 30'($urandom_range(1, 15));
        roll             = $urandom_range(0, 99);
        exc_evt.ex       = (roll < 3);
        exc_evt.ertn     = (roll >= 3) && (roll < 6);
        exc_evt.pc       = $urandom();
        exc_evt.vaddr    = $urandom();
        exc_evt.ecode    = pick_ecode($urandom_range(0, 3));
        exc_evt.esubcode = 9'($urandom_range(0, 1));
        if ($urandom_range(0, 99) < 2)
            hw_int_in = 8'($urandom());
        if ($urandom_range(0, 99) < 2)
            ipi_int_in = ~ipi_int_in;
    endtask

    initial begin : main
        reset      = 1'b1;
        csr_num    = csr_crmd;
        csr_wr     = '0;
        exc_evt    = '0;
        hw_int_in  = '0;
        ipi_int_in = 1'b0;
        void'($urandom(32'hc68c9fde));
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < run_cycles; i++) begin
            @(posedge clk);
            #1;
            drive_cycle();
        end
        @(posedge clk);
        #1;
        csr_wr.we    = 1'b0;
        exc_evt.ex   = 1'b0;
        exc_evt.ertn = 1'b0;
        repeat (2) @(posedge clk);  // Let the last comparisons land
        $display("Run finished: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not end within %0d cycles", timeout_cycles);
        $display("Run stopped: %0d checks, %0d errors", check_count, error_count);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== tb.f ====
common/csr_pkg.sv
logic/exc_state_regs.sv
logic/timer_int_regs.sv
logic/csr_read_combine.sv
logic/csr_top.sv
verif/csr_checker.sv
verif/csr_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failures
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module csr_tb -o csr_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/csr_sim > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation exited with an error"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "Result: FAIL"; exit 1; }
echo "Result: PASS"
exit 0
